// File: hdl/intc_pkg.sv
`default_nettype none

package intc_pkg;

    // Source and bus sizes.
    localparam int NUM_SRC   = 256;
    localparam int BYTE_W    = 8;
    localparam int NUM_BYTES = NUM_SRC / BYTE_W;
    localparam int SEL_W     = $clog2(NUM_BYTES);
    localparam int VEC_W     = $clog2(NUM_SRC);

    // Vector read when nothing is pending.
    localparam logic [VEC_W-1:0] NO_VEC = 8'hFF;

    // Command codes.
    // The upper three bits pick the class, the low five bits the byte index.
    localparam logic [BYTE_W-1:0] CMD_ENABLE_BASE = 8'h20;
    localparam logic [BYTE_W-1:0] CMD_TYPE_BASE   = 8'h40;
    localparam logic [BYTE_W-1:0] CMD_PEND_BASE   = 8'h60;
    localparam logic [BYTE_W-1:0] CMD_VECTOR      = 8'h80;
    localparam logic [BYTE_W-1:0] CMD_EOI         = 8'hFF;

    // Trigger type bit.
    localparam logic TRIG_EDGE  = 1'b0;
    localparam logic TRIG_LEVEL = 1'b1;

endpackage

`default_nettype wire

// File: hdl/byte_sel_register.sv
`timescale 1ns/1ps
`default_nettype none

module byte_sel_register (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          i_write,
    input  wire logic [intc_pkg::SEL_W-1:0]    i_byte_sel,
    input  wire logic [intc_pkg::BYTE_W-1:0]   i_data,
    output logic      [intc_pkg::BYTE_W-1:0]   o_data,
    output logic      [intc_pkg::NUM_SRC-1:0]  o_full_data
);

    import intc_pkg::*;

    logic [BYTE_W-1:0] r_bytes [NUM_BYTES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                r_bytes[i] <= '0;
            end
        end else if (i_write) begin
            r_bytes[i_byte_sel] <= i_data;
        end
    end

    // Selected byte for the bus.
    assign o_data = r_bytes[i_byte_sel];

    // Flattened view, byte 0 holds sources 0 to 7.
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            o_full_data[i*BYTE_W +: BYTE_W] = r_bytes[i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/intc_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module intc_cmd_decode (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          i_cs,
    input  wire logic                          i_rwb,
    input  wire logic                          i_addr,
    input  wire logic [intc_pkg::BYTE_W-1:0]   i_data,
    output logic      [intc_pkg::BYTE_W-1:0]   o_data,
    output logic                               o_enable_write,
    output logic                               o_type_write,
    output logic      [intc_pkg::SEL_W-1:0]    o_byte_sel,
    output logic                               o_eoi,
    input  wire logic [intc_pkg::BYTE_W-1:0]   i_enable_byte,
    input  wire logic [intc_pkg::BYTE_W-1:0]   i_type_byte,
    input  wire logic [intc_pkg::NUM_SRC-1:0]  i_pending,
    input  wire logic [intc_pkg::VEC_W-1:0]    i_vector
);

    import intc_pkg::*;

    logic [BYTE_W-1:0]       r_cmd;
    logic [BYTE_W-SEL_W-1:0] cmd_class;
    logic [SEL_W-1:0]        cmd_sel;
    logic [BYTE_W-1:0]       pend_byte;

    logic wr;
    logic rd;
    logic data_wr;

    logic is_enable;
    logic is_type;
    logic is_pend;
    logic is_vector;
    logic is_eoi;

    assign wr      = i_cs & ~i_rwb;
    assign rd      = i_cs & i_rwb & i_addr;
    assign data_wr = wr & i_addr;

    // Command register at address 0.
    always_ff @(posedge clk) begin
        if (reset) begin
            r_cmd <= '0;
        end else if (wr && !i_addr) begin
            r_cmd <= i_data;
        end
    end

    assign cmd_class = r_cmd[BYTE_W-1:SEL_W];
    assign cmd_sel   = r_cmd[SEL_W-1:0];

    // Command classes.
    assign is_enable = (cmd_class == CMD_ENABLE_BASE[BYTE_W-1:SEL_W]);
    assign is_type   = (cmd_class == CMD_TYPE_BASE[BYTE_W-1:SEL_W]);
    assign is_pend   = (cmd_class == CMD_PEND_BASE[BYTE_W-1:SEL_W]);
    assign is_vector = (r_cmd == CMD_VECTOR);
    assign is_eoi    = (r_cmd == CMD_EOI);

    // Strobes for the data window.
    assign o_byte_sel     = cmd_sel;
    assign o_enable_write = data_wr & is_enable;
    assign o_type_write   = data_wr & is_type;
    // EOI needs a data write with bit 0 set.
    assign o_eoi          = data_wr & is_eoi & i_data[0];

    assign pend_byte = i_pending[cmd_sel*BYTE_W +: BYTE_W];

    // Read mux, zero outside a data window read.
    always_comb begin
        o_data = '0;
        if (rd) begin
            if (is_enable) begin
                o_data = i_enable_byte;
            end else if (is_type) begin
                o_data = i_type_byte;
            end else if (is_pend) begin
                o_data = pend_byte;
            end else if (is_vector) begin
                o_data = i_vector;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/intc_source_latch.sv
`timescale 1ns/1ps
`default_nettype none

module intc_source_latch (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [intc_pkg::NUM_SRC-1:0]  i_int_in,
    input  wire logic [intc_pkg::NUM_SRC-1:0]  i_enable,
    input  wire logic [intc_pkg::NUM_SRC-1:0]  i_type,
    input  wire logic                          i_eoi,
    input  wire logic [intc_pkg::VEC_W-1:0]    i_vector,
    input  wire logic                          i_vector_valid,
    output logic      [intc_pkg::NUM_SRC-1:0]  o_pending
);

    import intc_pkg::*;

    logic [NUM_SRC-1:0] r_int_prev;
    logic [NUM_SRC-1:0] r_pending;
    logic [NUM_SRC-1:0] pending_next;
    logic [NUM_SRC-1:0] masked;
    logic [NUM_SRC-1:0] rise;
    logic               eoi_hit;

    assign masked = i_int_in & i_enable;
    // Edge seen against the raw previous sample.
    assign rise   = masked & ~r_int_prev;

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            eoi_hit = i_eoi && i_vector_valid && (i_vector == VEC_W'(i));
            case (i_type[i])
                TRIG_EDGE: begin
                    pending_next[i] = eoi_hit ? 1'b0 : (r_pending[i] | rise[i]);
                end
                TRIG_LEVEL: begin
                    // Still asserted sources survive EOI.
                    pending_next[i] = eoi_hit ? masked[i] : (r_pending[i] | masked[i]);
                end
                default: begin
                    pending_next[i] = r_pending[i];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_pending  <= '0;
            r_int_prev <= '0;
        end else begin
            r_pending  <= pending_next;
            r_int_prev <= i_int_in;
        end
    end

    assign o_pending = r_pending;

endmodule

`default_nettype wire

// File: hdl/intc_priority_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module intc_priority_encoder (
    input  wire logic [intc_pkg::NUM_SRC-1:0]  i_pending,
    output logic      [intc_pkg::VEC_W-1:0]    o_vector,
    output logic                               o_valid
);

    import intc_pkg::*;

    // Scan from the top so the lowest set bit wins.
    always_comb begin
        o_vector = NO_VEC;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (i_pending[i]) begin
                o_vector = VEC_W'(i);
            end
        end
    end

    assign o_valid = |i_pending;

endmodule

`default_nettype wire

// File: hdl/interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          i_cs,
    input  wire logic                          i_rwb,
    input  wire logic                          i_addr,
    input  wire logic [intc_pkg::BYTE_W-1:0]   i_data,
    output logic      [intc_pkg::BYTE_W-1:0]   o_data,
    input  wire logic [intc_pkg::NUM_SRC-1:0]  i_int_in,
    output logic                               o_int
);

    import intc_pkg::*;

    logic               w_enable_write;
    logic               w_type_write;
    logic [SEL_W-1:0]   w_byte_sel;
    logic               w_eoi;

    logic [BYTE_W-1:0]  w_enable_byte;
    logic [BYTE_W-1:0]  w_type_byte;
    logic [NUM_SRC-1:0] w_enable_full;
    logic [NUM_SRC-1:0] w_type_full;

    logic [NUM_SRC-1:0] w_pending;
    logic [VEC_W-1:0]   w_vector;
    logic               w_vector_valid;

    intc_cmd_decode u_cmd_decode (
        .clk            (clk),
        .reset          (reset),
        .i_cs           (i_cs),
        .i_rwb          (i_rwb),
        .i_addr         (i_addr),
        .i_data         (i_data),
        .o_data         (o_data),
        .o_enable_write (w_enable_write),
        .o_type_write   (w_type_write),
        .o_byte_sel     (w_byte_sel),
        .o_eoi          (w_eoi),
        .i_enable_byte  (w_enable_byte),
        .i_type_byte    (w_type_byte),
        .i_pending      (w_pending),
        .i_vector       (w_vector)
    );

    // Enable mask.
    byte_sel_register reg_enable (
        .clk         (clk),
        .reset       (reset),
        .i_write     (w_enable_write),
        .i_byte_sel  (w_byte_sel),
        .i_data      (i_data),
        .o_data      (w_enable_byte),
        .o_full_data (w_enable_full)
    );

    // Trigger type, edge or level.
    byte_sel_register reg_type (
        .clk         (clk),
        .reset       (reset),
        .i_write     (w_type_write),
        .i_byte_sel  (w_byte_sel),
        .i_data      (i_data),
        .o_data      (w_type_byte),
        .o_full_data (w_type_full)
    );

    intc_source_latch u_source_latch (
        .clk            (clk),
        .reset          (reset),
        .i_int_in       (i_int_in),
        .i_enable       (w_enable_full),
        .i_type         (w_type_full),
        .i_eoi          (w_eoi),
        .i_vector       (w_vector),
        .i_vector_valid (w_vector_valid),
        .o_pending      (w_pending)
    );

    intc_priority_encoder u_priority_encoder (
        .i_pending (w_pending),
        .o_vector  (w_vector),
        .o_valid   (w_vector_valid)
    );

    // Any pending source raises the line.
    assign o_int = w_vector_valid;

endmodule

`default_nettype wire

// File: verif/intc_chk.sv
`timescale 1ns/1ps
`default_nettype none

module intc_chk (
    input wire logic                          clk,
    input wire logic                          reset,
    input wire logic                          i_cs,
    input wire logic                          i_rwb,
    input wire logic                          i_addr,
    input wire logic [intc_pkg::BYTE_W-1:0]   i_rd_data,
    input wire logic [intc_pkg::NUM_SRC-1:0]  i_pending,
    input wire logic [intc_pkg::VEC_W-1:0]    i_vector,
    input wire logic                          i_int
);

    import intc_pkg::*;

    int fail_count = 0;

    logic [NUM_SRC-1:0] below_vec;

    // Sources numbered below the vector.
    assign below_vec = (NUM_SRC'(1) << i_vector) - 1'b1;

    // Line high means the vector is the lowest pending source.
    a_int_vector: assert property (@(posedge clk) disable iff (reset)
        i_int ? (i_pending[i_vector] && (i_pending & below_vec) == '0)
              : (i_vector == NO_VEC))
        else begin
            fail_count++;
            $error("o_int and the vector disagree with the pending bits");
        end

    a_data_idle: assert property (@(posedge clk) !(i_cs && i_rwb && i_addr) |-> i_rd_data == '0)
        else begin
            fail_count++;
            $error("o_data is not zero outside a read");
        end

    a_reset_clear: assert property (@(posedge clk) reset |=> (!i_int && i_rd_data == '0))
        else begin
            fail_count++;
            $error("o_int or o_data not zero after reset");
        end

endmodule

bind interrupt_controller intc_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .i_cs      (i_cs),
    .i_rwb     (i_rwb),
    .i_addr    (i_addr),
    .i_rd_data (o_data),
    .i_pending (w_pending),
    .i_vector  (w_vector),
    .i_int     (o_int)
);

`default_nettype wire

// File: verif/tb_interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_interrupt_controller;

    import intc_pkg::*;

    localparam time CLK_PERIOD   = 100ns;
    localparam time DRV_DELAY    = 10ns;
    localparam int  RESET_CYCLES = 8;

    // Approximate cycles per test, reset included.
    localparam int LEN_REGS   = 720;
    localparam int LEN_MASK   = 40;
    localparam int LEN_EDGE   = 50;
    localparam int LEN_LEVEL  = 50;
    localparam int LEN_PRIO   = 120;
    localparam int LEN_PEND   = 240;
    localparam int MAX_CYCLES =
        4 * (LEN_REGS + LEN_MASK + LEN_EDGE + LEN_LEVEL + LEN_PRIO + LEN_PEND);

    logic               clk;
    logic               reset;
    logic               i_cs;
    logic               i_rwb;
    logic               i_addr;
    logic [BYTE_W-1:0]  i_data;
    logic [BYTE_W-1:0]  o_data;
    logic [NUM_SRC-1:0] i_int_in;
    logic               o_int;

    // Reference model.
    logic [NUM_SRC-1:0] m_enable;
    logic [NUM_SRC-1:0] m_type;
    logic [NUM_SRC-1:0] m_pending;
    logic [NUM_SRC-1:0] m_prev;
    logic [BYTE_W-1:0]  m_cmd;

    string cur_test;
    int    err_count;
    int    check_count;
    int    tests_run;
    int    tests_failed;
    int    test_err_start;
    int    cycle_count;
    int    seed_val;

    interrupt_controller DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Lowest pending index, or -1.
    function automatic int lowest_pending(input logic [NUM_SRC-1:0] pend);
        for (int i = 0; i < NUM_SRC; i++) begin
            if (pend[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [VEC_W-1:0] expected_vector(input logic [NUM_SRC-1:0] pend);
        int v;
        v = lowest_pending(pend);
        return (v < 0) ? NO_VEC : VEC_W'(v);
    endfunction

    function automatic logic [NUM_SRC-1:0] next_pending(
        input logic [NUM_SRC-1:0] pend,
        input logic [NUM_SRC-1:0] src_in,
        input logic [NUM_SRC-1:0] prev,
        input logic [NUM_SRC-1:0] en,
        input logic [NUM_SRC-1:0] typ,
        input logic               eoi
    );
        logic [NUM_SRC-1:0] nxt;
        int                 v;
        v = lowest_pending(pend);
        for (int i = 0; i < NUM_SRC; i++) begin
            if (typ[i] == TRIG_LEVEL) begin
                nxt[i] = pend[i] | (src_in[i] & en[i]);
            end else begin
                nxt[i] = pend[i] | (src_in[i] & en[i] & ~prev[i]);
            end
        end
        // EOI retires the current vector.
        if (eoi && v >= 0) begin
            nxt[v] = (typ[v] == TRIG_LEVEL) ? (src_in[v] & en[v]) : 1'b0;
        end
        return nxt;
    endfunction

    function automatic logic [BYTE_W-1:0] model_byte(input logic [BYTE_W-1:0] cmd);
        if (cmd >= CMD_ENABLE_BASE && cmd < CMD_TYPE_BASE) begin
            return m_enable[int'(cmd - CMD_ENABLE_BASE) * BYTE_W +: BYTE_W];
        end else if (cmd >= CMD_TYPE_BASE && cmd < CMD_PEND_BASE) begin
            return m_type[int'(cmd - CMD_TYPE_BASE) * BYTE_W +: BYTE_W];
        end else if (cmd >= CMD_PEND_BASE && cmd < CMD_VECTOR) begin
            return m_pending[int'(cmd - CMD_PEND_BASE) * BYTE_W +: BYTE_W];
        end else if (cmd == CMD_VECTOR) begin
            return expected_vector(m_pending);
        end
        return '0;
    endfunction

    // Model follows the DUT inputs at every rising edge.
    always @(posedge clk) begin : model_update
        logic eoi;
        int   idx;
        if (reset) begin
            m_enable  = '0;
            m_type    = '0;
            m_pending = '0;
            m_prev    = '0;
            m_cmd     = '0;
        end else begin
            eoi = i_cs && !i_rwb && i_addr && (m_cmd == CMD_EOI) && i_data[0];
            m_pending = next_pending(m_pending, i_int_in, m_prev, m_enable, m_type, eoi);
            m_prev    = i_int_in;
            if (i_cs && !i_rwb && !i_addr) begin
                m_cmd = i_data;
            end else if (i_cs && !i_rwb) begin
                if (m_cmd >= CMD_ENABLE_BASE && m_cmd < CMD_TYPE_BASE) begin
                    idx = int'(m_cmd - CMD_ENABLE_BASE);
                    m_enable[idx*BYTE_W +: BYTE_W] = i_data;
                end else if (m_cmd >= CMD_TYPE_BASE && m_cmd < CMD_PEND_BASE) begin
                    idx = int'(m_cmd - CMD_TYPE_BASE);
                    m_type[idx*BYTE_W +: BYTE_W] = i_data;
                end
            end
        end
    end

    task automatic check_byte(input string label, input logic [BYTE_W-1:0] exp,
                              input logic [BYTE_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %s %s: expected %h, actual %h", cur_test, label, exp, act);
        end
    endtask

    task automatic check_vector(input string label, input logic [VEC_W-1:0] exp,
                                input logic [VEC_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %s %s: expected %h, actual %h", cur_test, label, exp, act);
        end
    endtask

    task automatic check_int(input string label, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %s %s: expected %b, actual %b", cur_test, label, exp, act);
        end
    endtask

    // Line compared mid cycle.
    always @(negedge clk) begin
        if (!reset) begin
            check_int("o_int", |m_pending, o_int);
        end
    end

    task automatic bus_idle();
        i_cs   = 1'b0;
        i_rwb  = 1'b1;
        i_addr = 1'b0;
        i_data = '0;
    endtask

    task automatic bus_write(input logic addr, input logic [BYTE_W-1:0] data);
        @(posedge clk);
        #DRV_DELAY;
        i_cs   = 1'b1;
        i_rwb  = 1'b0;
        i_addr = addr;
        i_data = data;
        @(posedge clk);
        #DRV_DELAY;
        bus_idle();
    endtask

    task automatic write_reg(input logic [BYTE_W-1:0] cmd, input logic [BYTE_W-1:0] data);
        bus_write(1'b0, cmd);
        bus_write(1'b1, data);
    endtask

    // Selects cmd, reads the window and compares at mid cycle.
    task automatic check_reg(input string label, input logic [BYTE_W-1:0] cmd);
        logic [BYTE_W-1:0] got;
        logic [BYTE_W-1:0] exp;
        bus_write(1'b0, cmd);
        @(posedge clk);
        #DRV_DELAY;
        i_cs   = 1'b1;
        i_rwb  = 1'b1;
        i_addr = 1'b1;
        @(negedge clk);
        got = o_data;
        exp = model_byte(cmd);
        @(posedge clk);
        #DRV_DELAY;
        bus_idle();
        if (cmd == CMD_VECTOR) begin
            check_vector(label, exp, got);
        end else begin
            check_byte(label, exp, got);
        end
    endtask

    task automatic issue_eoi();
        write_reg(CMD_EOI, 8'h01);
    endtask

    task automatic drive_inputs(input logic [NUM_SRC-1:0] value);
        @(posedge clk);
        #DRV_DELAY;
        i_int_in = value;
    endtask

    task automatic setup_source(input int src, input logic trig);
        logic [BYTE_W-1:0] en_byte;
        logic [BYTE_W-1:0] ty_byte;
        en_byte = m_enable[(src / BYTE_W) * BYTE_W +: BYTE_W];
        ty_byte = m_type[(src / BYTE_W) * BYTE_W +: BYTE_W];
        en_byte[src % BYTE_W] = 1'b1;
        ty_byte[src % BYTE_W] = trig;
        write_reg(CMD_ENABLE_BASE + BYTE_W'(src / BYTE_W), en_byte);
        write_reg(CMD_TYPE_BASE + BYTE_W'(src / BYTE_W), ty_byte);
    endtask

    task automatic begin_test(input string name);
        i_int_in = '0;
        reset    = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRV_DELAY;
        reset          = 1'b0;
        cur_test       = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, err_count - test_err_start);
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, test %s did not finish", cycle_count, cur_test);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        logic [NUM_SRC-1:0] pattern;
        int                 src;
        int                 lo;
        int                 hi;
        seed_val       = $urandom(32'h92be);
        err_count      = 0;
        check_count    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        cur_test       = "reset";
        reset          = 1'b1;
        i_int_in       = '0;
        bus_idle();

        begin_test("register_access");
        for (int i = 0; i < NUM_BYTES; i++) begin
            check_reg("reset enable", CMD_ENABLE_BASE + BYTE_W'(i));
            check_reg("reset type", CMD_TYPE_BASE + BYTE_W'(i));
            check_reg("reset pending", CMD_PEND_BASE + BYTE_W'(i));
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(CMD_ENABLE_BASE + BYTE_W'($urandom % NUM_BYTES), BYTE_W'($urandom));
            write_reg(CMD_TYPE_BASE + BYTE_W'($urandom % NUM_BYTES), BYTE_W'($urandom));
        end
        for (int i = 0; i < NUM_BYTES; i++) begin
            check_reg("enable readback", CMD_ENABLE_BASE + BYTE_W'(i));
            check_reg("type readback", CMD_TYPE_BASE + BYTE_W'(i));
        end
        end_test();

        begin_test("masking");
        src          = $urandom % NUM_SRC;
        pattern      = '0;
        pattern[src] = 1'b1;
        repeat (2) begin
            drive_inputs(pattern);
            drive_inputs('0);
        end
        check_reg("masked pending", CMD_PEND_BASE + BYTE_W'(src / BYTE_W));
        setup_source(src, TRIG_EDGE);
        repeat (3) drive_inputs('0);
        check_reg("pending after enable", CMD_PEND_BASE + BYTE_W'(src / BYTE_W));
        check_reg("vector", CMD_VECTOR);
        end_test();

        begin_test("edge_trigger");
        lo = $urandom % (NUM_SRC - 1);
        hi = lo + 1 + ($urandom % (NUM_SRC - 1 - lo));
        setup_source(lo, TRIG_EDGE);
        setup_source(hi, TRIG_EDGE);
        pattern     = '0;
        pattern[lo] = 1'b1;
        pattern[hi] = 1'b1;
        drive_inputs(pattern);
        drive_inputs('0);
        check_reg("pending", CMD_PEND_BASE + BYTE_W'(lo / BYTE_W));
        check_reg("first vector", CMD_VECTOR);
        issue_eoi();
        check_reg("second vector", CMD_VECTOR);
        issue_eoi();
        check_reg("empty vector", CMD_VECTOR);
        end_test();

        begin_test("level_trigger");
        src          = $urandom % NUM_SRC;
        pattern      = '0;
        pattern[src] = 1'b1;
        setup_source(src, TRIG_LEVEL);
        drive_inputs(pattern);
        check_reg("vector", CMD_VECTOR);
        issue_eoi();
        check_reg("held pending", CMD_PEND_BASE + BYTE_W'(src / BYTE_W));
        drive_inputs('0);
        check_reg("vector after release", CMD_VECTOR);
        issue_eoi();
        check_reg("empty vector", CMD_VECTOR);
        end_test();

        begin_test("priority_order");
        pattern = '0;
        for (int i = 0; i < 6; i++) begin
            src = $urandom % NUM_SRC;
            setup_source(src, TRIG_EDGE);
            pattern[src] = 1'b1;
        end
        drive_inputs(pattern);
        drive_inputs('0);
        while (m_pending != '0) begin
            check_reg("vector", CMD_VECTOR);
            issue_eoi();
        end
        check_reg("empty vector", CMD_VECTOR);
        end_test();

        begin_test("pending_bytes");
        for (int i = 0; i < 12; i++) begin
            setup_source($urandom % NUM_SRC, 1'($urandom));
        end
        repeat (4) begin
            for (int k = 0; k < NUM_SRC / 32; k++) begin
                pattern[k*32 +: 32] = $urandom;
            end
            drive_inputs(pattern);
        end
        for (int i = 0; i < NUM_BYTES; i++) begin
            check_reg("pending byte", CMD_PEND_BASE + BYTE_W'(i));
        end
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_count, err_count, DUT.u_chk.fail_count);
        if (tests_failed == 0 && err_count == 0 && DUT.u_chk.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/intc_pkg.sv
hdl/byte_sel_register.sv
hdl/intc_cmd_decode.sv
hdl/intc_source_latch.sv
hdl/intc_priority_encoder.sv
hdl/interrupt_controller.sv
verif/intc_chk.sv
verif/tb_interrupt_controller.sv

// File: Bender.yml
package:
  name: interrupt_controller

sources:
  - hdl/intc_pkg.sv
  - hdl/byte_sel_register.sv
  - hdl/intc_cmd_decode.sv
  - hdl/intc_source_latch.sv
  - hdl/intc_priority_encoder.sv
  - hdl/interrupt_controller.sv
  - target: test
    files:
      - verif/intc_chk.sv
      - verif/tb_interrupt_controller.sv
